/* list.f */
hdl/road_pkg.sv
hdl/road_cpu_port.sv
hdl/road_line_ram.sv
hdl/road_line_fetch.sv
hdl/road_layer.sv
hdl/road_mixer.sv
hdl/road_top.sv
bench/road_tb_clk.sv
bench/road_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the road layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module road_tb \
    --Mdir obj_dir -o road_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/road_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0

/* bench/road_tb.sv */
module road_tb;

    // lines each test runs, summed, plus slack for setup writes
    localparam int test_lines = 26;
    localparam int cycle_limit = test_lines * 384 * 2 + 4000;

    logic                clk;
    logic                rst = 1'b1;
    logic                pxl_cen = 1'b0;
    logic                hs = 1'b0;
    logic [8:0]          v = 9'd0;
    road_pkg::wb_req_s   wb_in = '0;
    road_pkg::wb_rsp_s   wb_out;
    road_pkg::rom_req_s  rom0_out;
    road_pkg::rom_rsp_s  rom0_in = '0;
    road_pkg::rom_req_s  rom1_out;
    road_pkg::rom_rsp_s  rom1_in = '0;
    road_pkg::road_out_s out;

    int          hcnt = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'h4992_21ac;
    logic [15:0] rd;

    road_tb_clk u_clk (
        .clk (clk)
    );

    road_top u_road_top (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hs       (hs),
        .v        (v),
        .wb_in    (wb_in),
        .wb_out   (wb_out),
        .rom0_out (rom0_out),
        .rom0_in  (rom0_in),
        .rom1_out (rom1_out),
        .rom1_in  (rom1_in),
        .out      (out)
    );

    // rom line 1 gives pattern 1, line 2 pattern 2
    function automatic logic [15:0] rom_word(input logic [13:0] addr);
        case (addr[13:6])
            8'd1: rom_word = 16'h00ff;
            8'd2: rom_word = 16'hff00;
            default: rom_word = 16'h8080;
        endcase
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            rom0_in <= '0;
            rom1_in <= '0;
        end else begin
            if (rom0_out.cs) begin
                rom0_in <= '{ok: 1'b1, data: rom_word(rom0_out.addr)};
            end else begin
                rom0_in.ok <= 1'b0;
            end
            if (rom1_out.cs) begin
                rom1_in <= '{ok: 1'b1, data: rom_word(rom1_out.addr)};
            end else begin
                rom1_in.ok <= 1'b0;
            end
        end
    end

    // 384 pixels a line, first 64 in sync
    always @(posedge clk) begin
        if (rst) begin
            pxl_cen <= 1'b0;
            hcnt    <= 0;
            hs      <= 1'b1;
            v       <= 9'd0;
        end else begin
            pxl_cen <= ~pxl_cen;
            if (pxl_cen) begin
                if (hcnt == 383) begin
                    hcnt <= 0;
                    hs   <= 1'b1;
                    v    <= v + 9'd1;
                end else begin
                    hcnt <= hcnt + 1;
                    if (hcnt == 63) begin
                        hs <= 1'b0;
                    end
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: tests still running after %0d cycles", cycles);
            $display("=== FAIL ===");
            $finish;
        end
    end

    task automatic rand_bits(input int n, output logic [31:0] r);
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
    endtask

    task automatic check_word(input logic [15:0] got, input logic [15:0] exp,
                              input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, msg, got, exp);
        end
    endtask

    task automatic check_out(input road_pkg::road_out_s got,
                             input road_pkg::road_out_s exp, input int k);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: pixel %0d got %h/%b/%b expected %h/%b/%b", $time, k,
                     got.pxl, got.from_rom_n, got.blank_or_fixed,
                     exp.pxl, exp.from_rom_n, exp.blank_or_fixed);
        end
    endtask

    // one classic cycle, strobe held for extra cycles after the first ack
    task automatic wb_access(input logic we, input logic [1:0] sel, input logic [11:0] adr,
                             input logic [15:0] dat, input int hold,
                             output logic [15:0] rdat);
        int n;
        n = 0;
        @(posedge clk);
        wb_in <= '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
        do begin
            @(posedge clk);
            n++;
        end while (!wb_out.ack && n < 20);
        if (!wb_out.ack) begin
            errors++;
            $display("no Wishbone ack for address %h", adr);
        end
        rdat = wb_out.dat;
        repeat (hold) @(posedge clk);
        wb_in <= '0;
    endtask

    task automatic set_mode(input road_pkg::road_mode_e m);
        logic [15:0] d;
        wb_access(1'b1, 2'b01, 12'h800, {14'd0, m}, 0, d);
    endtask

    // fill index areas for every line, then swap so video sees them
    task automatic load_lines(input logic [11:0] idx0, input logic [11:0] idx1,
                              input logic [11:0] scr0, input logic [11:0] scr1,
                              input logic [11:0] col0, input logic [11:0] col1);
        logic [15:0] d;
        for (int i = 0; i < 256; i++) begin
            wb_access(1'b1, 2'b11, 12'(i), {4'd0, idx0}, 0, d);
            wb_access(1'b1, 2'b11, 12'(256 + i), {4'd0, idx1}, 0, d);
        end
        wb_access(1'b1, 2'b11, {3'b001, idx0[8:0]}, {4'd0, scr0}, 0, d);
        wb_access(1'b1, 2'b11, {3'b010, idx1[8:0]}, {4'd0, scr1}, 0, d);
        wb_access(1'b1, 2'b11, {3'b011, idx0[8:0]}, {4'd0, col0}, 0, d);
        wb_access(1'b1, 2'b11, {3'b011, idx1[8:0]}, {4'd0, col1}, 0, d);
        wb_access(1'b0, 2'b11, 12'h800, 16'd0, 0, d);
    endtask

    task automatic wait_hs_rise();
        @(posedge clk);
        while (hs) @(posedge clk);
        while (!hs) @(posedge clk);
    endtask

    // active pixel k checked against exp_in or exp_out by range
    task automatic verify_line(input road_pkg::road_out_s exp_in, input int lo_in,
                               input int hi_in, input road_pkg::road_out_s exp_out,
                               input int lo_out, input int hi_out);
        int k;
        k = 0;
        wait_hs_rise();
        while (hs) @(posedge clk);
        while (!hs) begin
            if (pxl_cen) begin
                if (k >= lo_in && k <= hi_in) begin
                    check_out(out, exp_in, k);
                end else if (k >= lo_out && k <= hi_out) begin
                    check_out(out, exp_out, k);
                end
                k++;
            end
            @(posedge clk);
        end
    endtask

    task automatic reset_defaults();
        check_word({15'd0, wb_out.ack}, 16'd0, "ack after reset");
        check_word({15'd0, rom0_out.cs}, 16'd0, "rom0 cs after reset");
        check_word({15'd0, rom1_out.cs}, 16'd0, "rom1 cs after reset");
        wb_access(1'b0, 2'b11, 12'h800, 16'd0, 0, rd);
        check_word(rd, 16'd0, "mode after reset");
    endtask

    task automatic byte_lanes();
        logic [31:0] r;
        logic [11:0] adr;
        logic [15:0] d1;
        logic [15:0] d2;
        logic [1:0]  sel;
        for (int i = 0; i < 8; i++) begin
            rand_bits(11, r);
            adr = {1'b0, r[10:0]};
            rand_bits(16, r);
            d1 = r[15:0];
            rand_bits(16, r);
            d2 = r[15:0];
            rand_bits(1, r);
            sel = r[0] ? 2'b01 : 2'b10;
            wb_access(1'b1, 2'b11, adr, d1, 0, rd);
            wb_access(1'b1, sel, adr, d2, 0, rd);
            wb_access(1'b0, 2'b11, adr, 16'd0, 0, rd);
            check_word(rd, {sel[1] ? d2[15:8] : d1[15:8], sel[0] ? d2[7:0] : d1[7:0]},
                       "byte lane read-back");
        end
    endtask

    task automatic bank_swap();
        wb_access(1'b1, 2'b11, 12'h7f3, 16'h1234, 0, rd);
        wb_access(1'b0, 2'b11, 12'h800, 16'd0, 0, rd);
        wb_access(1'b1, 2'b11, 12'h7f3, 16'hbeef, 0, rd);
        wb_access(1'b0, 2'b11, 12'h7f3, 16'd0, 0, rd);
        check_word(rd, 16'hbeef, "word in swapped bank");
        wb_access(1'b0, 2'b11, 12'h800, 16'd0, 0, rd);
        wb_access(1'b0, 2'b11, 12'h7f3, 16'd0, 0, rd);
        check_word(rd, 16'h1234, "word after second swap");
        // long strobe must flip the bank only once
        wb_access(1'b0, 2'b11, 12'h800, 16'd0, 6, rd);
        wb_access(1'b0, 2'b11, 12'h7f3, 16'd0, 0, rd);
        check_word(rd, 16'hbeef, "word after held control read");
    endtask

    task automatic both_roads_off();
        road_pkg::road_out_s e;
        set_mode(road_pkg::only_road0);
        load_lines(12'h835, 12'h84a, 12'h000, 12'h000, 12'h000, 12'h000);
        wait_hs_rise();
        e = '{pxl: 8'hca, from_rom_n: 1'b1, blank_or_fixed: 1'b1};
        verify_line(e, 8, 150, e, 151, 310);
        // layer 1 takes priority so layer 0 colour shows
        set_mode(road_pkg::road1_prio);
        wait_hs_rise();
        e = '{pxl: 8'hb5, from_rom_n: 1'b1, blank_or_fixed: 1'b1};
        verify_line(e, 8, 150, e, 151, 310);
    endtask

    task automatic road0_alone();
        road_pkg::road_out_s ei;
        road_pkg::road_out_s eo;
        set_mode(road_pkg::only_road0);
        load_lines(12'h002, 12'h800, 12'h76a, 12'h000, 12'h5a6, 12'h000);
        wait_hs_rise();
        ei = '{pxl: 8'h03, from_rom_n: 1'b0, blank_or_fixed: 1'b0};
        eo = '{pxl: 8'h06, from_rom_n: 1'b0, blank_or_fixed: 1'b0};
        verify_line(ei, 24, 130, eo, 170, 310);
    endtask

    task automatic priority_modes();
        road_pkg::road_out_s ei;
        road_pkg::road_out_s eo;
        set_mode(road_pkg::road0_prio);
        load_lines(12'h002, 12'h004, 12'h76a, 12'h76a, 12'h5a6, 12'h3c9);
        wait_hs_rise();
        ei = '{pxl: 8'h03, from_rom_n: 1'b0, blank_or_fixed: 1'b0};
        eo = '{pxl: 8'h06, from_rom_n: 1'b0, blank_or_fixed: 1'b0};
        verify_line(ei, 24, 130, eo, 170, 310);
        set_mode(road_pkg::road1_prio);
        wait_hs_rise();
        eo = '{pxl: 8'h0f, from_rom_n: 1'b0, blank_or_fixed: 1'b0};
        verify_line(ei, 24, 130, eo, 170, 310);
    endtask

    initial begin
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        reset_defaults();
        byte_lanes();
        bank_swap();
        both_roads_off();
        road0_alone();
        priority_modes();
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* bench/road_tb_clk.sv */
module road_tb_clk (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // 10 unit period
    always begin
        #5 clk = ~clk;
    end

endmodule

/* hdl/road_top.sv */
module road_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               pxl_cen,
    input  logic               hs,
    input  logic [8:0]         v,
    input  road_pkg::wb_req_s  wb_in,
    output road_pkg::wb_rsp_s  wb_out,
    output road_pkg::rom_req_s rom0_out,
    input  road_pkg::rom_rsp_s rom0_in,
    output road_pkg::rom_req_s rom1_out,
    input  road_pkg::rom_rsp_s rom1_in,
    output road_pkg::road_out_s out
);

    logic [15:0]                  ram_rd;
    logic [1:0]                   ram_we;
    logic                         bank;
    road_pkg::road_mode_e         mode;
    logic [road_pkg::line_aw-1:0] vid_adr;
    logic [15:0]                  vid_rdat;
    road_pkg::road_line_s         line0;
    road_pkg::road_line_s         line1;
    road_pkg::road_pix_s          pix0;
    road_pkg::road_pix_s          pix1;

    road_cpu_port u_cpu_port (
        .clk    (clk),
        .rst    (rst),
        .wb_in  (wb_in),
        .wb_out (wb_out),
        .ram_rd (ram_rd),
        .ram_we (ram_we),
        .bank   (bank),
        .mode   (mode)
    );

    road_line_ram u_line_ram (
        .clk      (clk),
        .bank     (bank),
        .cpu_adr  (wb_in.adr[road_pkg::cpu_aw-1:0]),
        .cpu_wdat (wb_in.dat),
        .cpu_we   (ram_we),
        .cpu_rdat (ram_rd),
        .vid_adr  (vid_adr),
        .vid_rdat (vid_rdat)
    );

    road_line_fetch u_line_fetch (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .hs       (hs),
        .v        (v),
        .vid_adr  (vid_adr),
        .vid_rdat (vid_rdat),
        .line0    (line0),
        .line1    (line1)
    );

    road_layer u_layer0 (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .hs      (hs),
        .line    (line0),
        .rom_out (rom0_out),
        .rom_in  (rom0_in),
        .pix     (pix0)
    );

    road_layer u_layer1 (
        .clk     (clk),
        .rst     (rst),
        .pxl_cen (pxl_cen),
        .hs      (hs),
        .line    (line1),
        .rom_out (rom1_out),
        .rom_in  (rom1_in),
        .pix     (pix1)
    );

    road_mixer u_mixer (
        .clk     (clk),
        .pxl_cen (pxl_cen),
        .hs      (hs),
        .mode    (mode),
        .pa      (pix0),
        .pb      (pix1),
        .line0   (line0),
        .line1   (line1),
        .out     (out)
    );

endmodule

/* hdl/road_mixer.sv */
module road_mixer (
    input  logic                 clk,
    input  logic                 pxl_cen,
    input  logic                 hs,
    input  road_pkg::road_mode_e mode,
    input  road_pkg::road_pix_s  pa,
    input  road_pkg::road_pix_s  pb,
    input  road_pkg::road_line_s line0,
    input  road_pkg::road_line_s line1,
    output road_pkg::road_out_s  out
);

    logic       m_only0, m_only1, m_prio0, m_prio1;
    logic       a_clear, b_clear;
    logic       b_cent3;
    logic       from_rom_n;
    logic       blank_or_fixed;
    logic       force_b;
    logic       win;
    logic [1:0] code;
    logic [11:0] col;
    road_pkg::road_pix_s sel;
    road_pkg::road_out_s nxt;

    assign m_only0 = mode == road_pkg::only_road0;
    assign m_only1 = mode == road_pkg::only_road1;
    assign m_prio0 = mode == road_pkg::road0_prio;
    assign m_prio1 = mode == road_pkg::road1_prio;

    // pattern 3 is see-through before the centre line
    assign a_clear = !pa.cent && pa.pxl == 2'd3;
    assign b_clear = !pb.cent && pb.pxl == 2'd3;
    assign b_cent3 = pb.cent && pb.pxl == 2'd3;

    always_comb begin
        from_rom_n = (line0.idx.rom.off && line1.idx.rom.off) ||
                     (line0.idx.rom.off && m_only0) ||
                     (line1.idx.rom.off && m_only1);
        blank_or_fixed = from_rom_n || (a_clear && b_clear) ||
                         (b_clear && m_only1) || (a_clear && m_only0);

        // layer 1 forced during sync unless the output is fixed
        force_b = hs && !(from_rom_n && blank_or_fixed);

        // high picks layer 1
        win = force_b || m_only1 ||
              (a_clear && b_clear && m_prio1) ||
              (a_clear && b_cent3 && m_prio0) ||
              (a_clear && pb.pxl == 2'd1 && m_prio0) ||
              (a_clear && pb.pxl == 2'd2 && m_prio0) ||
              (a_clear && !pb.pxl[0] && m_prio1) ||
              (a_clear && !pb.pxl[1] && m_prio1) ||
              (!pa.cent && pa.pxl[0] && pb.pxl == 2'd0 && m_prio0) ||
              (!pa.cent && pa.pxl[1] && pb.pxl == 2'd0 && m_prio0) ||
              (b_cent3 && m_prio1) ||
              (b_cent3 && !pa.pxl[0] && m_prio0) ||
              (b_cent3 && !pa.pxl[1] && m_prio0) ||
              (!pa.pxl[0] && pb.pxl == 2'd0 && m_prio1) ||
              (!pa.pxl[1] && pb.pxl == 2'd0 && m_prio1);

        sel = win ? pb : pa;
        code[0] = sel.pxl == 2'd1 || (sel.cent && sel.pxl == 2'd3);
        code[1] = sel.pxl == 2'd2 || (sel.cent && sel.pxl == 2'd3);
        col = win ? line1.col : line0.col;

        if (!blank_or_fixed) begin
            nxt.pxl = {4'd0, win, code, col[{win, code}]};
        end else if (from_rom_n) begin
            // solid colour from the layer that lost
            nxt.pxl = {1'b1, win ? line0.idx.solid.color : line1.idx.solid.color};
        end else begin
            nxt.pxl = {3'b001, win, col[11:8]};
        end
        nxt.from_rom_n     = from_rom_n;
        nxt.blank_or_fixed = blank_or_fixed;
    end

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            out <= nxt;
        end
    end

endmodule

/* hdl/road_layer.sv */
module road_layer (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  logic                 hs,
    input  road_pkg::road_line_s line,
    output road_pkg::rom_req_s   rom_out,
    input  road_pkg::rom_rsp_s   rom_in,
    output road_pkg::road_pix_s  pix
);

    logic [11:0] hpos;
    logic [15:0] shifter;
    logic        in_window;
    logic        en;
    logic        cent;

    assign in_window = hpos[11:9] == road_pkg::hpos_window;
    assign en        = !line.idx.rom.off && in_window;

    assign rom_out.addr = {line.idx.rom.line, hpos[8:3]};

    // two bitplanes, one in each byte
    assign pix.pxl  = {shifter[15], shifter[7]};
    assign pix.cent = cent;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_out.cs <= 1'b0;
            hpos       <= 12'd0;
            cent       <= 1'b0;
        end else if (hs) begin
            rom_out.cs <= 1'b0;
            hpos       <= line.scr;
            cent       <= 1'b0;
        end else if (pxl_cen) begin
            rom_out.cs <= en;
            hpos       <= hpos + 12'd1;
            // past the window or its middle
            if (!in_window || hpos[8:0] == 9'hff) begin
                cent <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hs) begin
            shifter <= 16'hffff;
        end else if (pxl_cen) begin
            if (hpos[2:0] == 3'd0) begin
                // data taken as is, ok not checked
                shifter <= en ? rom_in.data : 16'hffff;
            end else begin
                shifter <= shifter << 1;
            end
        end
    end

endmodule

/* hdl/road_line_fetch.sv */
module road_line_fetch (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         pxl_cen,
    input  logic                         hs,
    input  logic [8:0]                   v,
    output logic [road_pkg::line_aw-1:0] vid_adr,
    input  logic [15:0]                  vid_rdat,
    output road_pkg::road_line_s         line0,
    output road_pkg::road_line_s         line1
);

    logic [2:0] st;

    // areas: index 0, index 1, scroll 0, scroll 1, colours
    always_comb begin
        case (st)
            3'd0: vid_adr = {3'd0, v[7:0]};
            3'd1: vid_adr = {3'd1, v[7:0]};
            3'd2: vid_adr = {2'd1, line0.idx[8:0]};
            3'd3: vid_adr = {2'd2, line1.idx[8:0]};
            3'd4: vid_adr = {2'd3, line0.idx[8:0]};
            default: vid_adr = {2'd3, line1.idx[8:0]};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st    <= 3'd0;
            line0 <= '0;
            line1 <= '0;
        end else if (pxl_cen) begin
            if (hs) begin
                if (st < 3'd6) begin
                    st <= st + 3'd1;
                end
                // word for this step arrived one clock after its address
                case (st)
                    3'd0: line0.idx <= road_pkg::road_idx_u'(vid_rdat[11:0]);
                    3'd1: line1.idx <= road_pkg::road_idx_u'(vid_rdat[11:0]);
                    3'd2: line0.scr <= vid_rdat[11:0];
                    3'd3: line1.scr <= vid_rdat[11:0];
                    3'd4: line0.col <= vid_rdat[11:0];
                    3'd5: line1.col <= vid_rdat[11:0];
                    default: ;
                endcase
            end else begin
                st <= 3'd0;
            end
        end
    end

endmodule

/* hdl/road_line_ram.sv */
module road_line_ram (
    input  logic                        clk,
    input  logic                        bank,
    input  logic [road_pkg::cpu_aw-1:0] cpu_adr,
    input  logic [15:0]                 cpu_wdat,
    input  logic [1:0]                  cpu_we,
    output logic [15:0]                 cpu_rdat,
    input  logic [road_pkg::line_aw-1:0] vid_adr,
    output logic [15:0]                 vid_rdat
);

    // two banks of line words, bank bit on top of the address
    logic [15:0] mem [0:4095];

    logic [11:0] cpu_full;
    logic [11:0] vid_full;

    // CPU works on the bank the video is not reading
    assign cpu_full = {~bank, cpu_adr};
    assign vid_full = {bank, vid_adr};

    always_ff @(posedge clk) begin
        if (cpu_we[0]) begin
            mem[cpu_full][7:0] <= cpu_wdat[7:0];
        end
        if (cpu_we[1]) begin
            mem[cpu_full][15:8] <= cpu_wdat[15:8];
        end
        cpu_rdat <= mem[cpu_full];
    end

    always_ff @(posedge clk) begin
        vid_rdat <= mem[vid_full];
    end

endmodule

/* hdl/road_cpu_port.sv */
module road_cpu_port (
    input  logic                   clk,
    input  logic                   rst,
    input  road_pkg::wb_req_s      wb_in,
    output road_pkg::wb_rsp_s      wb_out,
    input  logic [15:0]            ram_rd,
    output logic [1:0]             ram_we,
    output logic                   bank,
    output road_pkg::road_mode_e   mode
);

    logic access;
    logic ctrl_sel;
    logic ack;
    logic toggle;

    assign access   = wb_in.cyc & wb_in.stb;
    assign ctrl_sel = wb_in.adr[road_pkg::ctrl_adr_bit];

    // byte lanes reach the RAM only, once per strobe
    assign ram_we = {2{access & wb_in.we & ~ctrl_sel & ~ack}} & wb_in.sel;

    // RAM latency of one clock is hidden behind the ack delay
    assign wb_out.ack = ack;
    assign wb_out.dat = ctrl_sel ? {14'd0, mode} : ram_rd;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ack <= 1'b0;
        end else begin
            // one cycle high, then one low before the next strobe
            ack <= access & ~ack;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode <= road_pkg::only_road0;
        end else if (access && wb_in.we && ctrl_sel && wb_in.sel[0]) begin
            mode <= road_pkg::road_mode_e'(wb_in.dat[1:0]);
        end
    end

    // each control read flips the bank once, however long it is held
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank   <= 1'b0;
            toggle <= 1'b0;
        end else if (!(access && ctrl_sel)) begin
            toggle <= 1'b0;
        end else if (!wb_in.we) begin
            if (!toggle) begin
                bank <= ~bank;
            end
            toggle <= 1'b1;
        end
    end

endmodule

/* hdl/road_pkg.sv */
package road_pkg;

    // video-side line RAM address width, one bank
    localparam int line_aw = 11;
    // CPU word address width into the line RAM
    localparam int cpu_aw = 11;
    // address bit that selects the control register instead of the RAM
    localparam int ctrl_adr_bit = 11;
    // top three hpos bits while the road is inside its drawing window
    localparam logic [2:0] hpos_window = 3'd3;
    // road graphics ROM word address width
    localparam int rom_aw = 14;

    // index word read as a ROM line number
    typedef struct packed {
        logic       off;
        logic [1:0] unused_hi;
        logic [7:0] line;
        logic       unused_lo;
    } road_idx_rom_s;

    // same index word read as a solid colour
    typedef struct packed {
        logic       off;
        logic [3:0] unused;
        logic [6:0] color;
    } road_idx_solid_s;

    typedef union packed {
        road_idx_rom_s   rom;
        road_idx_solid_s solid;
    } road_idx_u;

    // col: background colour in 11..8, per-pattern colour bits in 7..0
    typedef struct packed {
        road_idx_u   idx;
        logic [11:0] scr;
        logic [11:0] col;
    } road_line_s;

    typedef enum logic [1:0] {
        only_road0 = 2'd0,
        road0_prio = 2'd1,
        road1_prio = 2'd2,
        only_road1 = 2'd3
    } road_mode_e;

    // adr carries the RAM word address plus the control select bit on top
    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [1:0]          sel;
        logic [ctrl_adr_bit:0] adr;
        logic [15:0]         dat;
    } wb_req_s;

    typedef struct packed {
        logic        ack;
        logic [15:0] dat;
    } wb_rsp_s;

    typedef struct packed {
        logic              cs;
        logic [rom_aw-1:0] addr;
    } rom_req_s;

    typedef struct packed {
        logic        ok;
        logic [15:0] data;
    } rom_rsp_s;

    typedef struct packed {
        logic [1:0] pxl;
        logic       cent;
    } road_pix_s;

    typedef struct packed {
        logic [7:0] pxl;
        logic       from_rom_n;
        logic       blank_or_fixed;
    } road_out_s;

endpackage
